// ==== hdl/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

   localparam int addr_w     = 32;
   localparam int data_w     = 32;
   localparam int ram_words  = 1024;
   localparam int text_words = 512;

   typedef logic [addr_w-1:0]   addr_t;
   typedef logic [data_w-1:0]   data_t;
   typedef logic [data_w/8-1:0] strb_t;
   typedef logic [1:0]          resp_t;

   // word index inside a region, address bits 11..2
   typedef logic [9:0] word_idx_t;
   // text buffer index, address bits 10..2
   typedef logic [8:0] text_idx_t;

   // region map
   localparam addr_t ram_base       = 32'h1c00_0000;
   localparam int    ram_span_bits  = 16;
   localparam addr_t text_base      = 32'h0001_0000;
   localparam int    text_span_bits = 12;

   localparam resp_t resp_okay   = 2'b00;
   localparam resp_t resp_decerr = 2'b11;

   typedef struct packed {
      logic      ram_sel;
      logic      text_sel;
      word_idx_t word_idx;
   } decode_t;

   // one write, shared by both memories
   typedef struct packed {
      word_idx_t word_idx;
      data_t     wdata;
      strb_t     wstrb;
   } mem_wr_t;

   typedef enum logic [1:0] {
      st_idle,
      st_read_wait,
      st_read_resp,
      st_write_resp
   } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hdl/addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
   input  wire soc_pkg::addr_t awaddr,
   input  wire soc_pkg::addr_t araddr,
   input  wire logic           wr_grant,
   output soc_pkg::decode_t    dec
);
   import soc_pkg::*;

   addr_t addr;
   logic  ram_hit;
   logic  text_hit;

   // write channel has the address while it is granted
   assign addr = wr_grant ? awaddr : araddr;

   // compare only the bits above each region size
   assign ram_hit  = (addr[addr_w-1:ram_span_bits] == ram_base[addr_w-1:ram_span_bits]);
   assign text_hit = (addr[addr_w-1:text_span_bits] == text_base[addr_w-1:text_span_bits]);

   always_comb begin
      dec          = '0;
      dec.ram_sel  = ram_hit;
      dec.text_sel = text_hit;
      dec.word_idx = addr[$bits(word_idx_t)+1:2];
   end

endmodule

`default_nettype wire

// ==== hdl/sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
   input  wire logic               clk,
   input  wire logic               we,
   input  wire logic               re,
   input  wire soc_pkg::mem_wr_t   wr,
   input  wire soc_pkg::word_idx_t rd_idx,
   output soc_pkg::data_t          rdata
);
   import soc_pkg::*;

   data_t mem [ram_words];

   // byte lanes follow the strobe bits
   always_ff @(posedge clk) begin
      if (we) begin
         for (int b = 0; b < $bits(strb_t); b++) begin
            if (wr.wstrb[b]) begin
               mem[wr.word_idx][b*8 +: 8] <= wr.wdata[b*8 +: 8];
            end
         end
      end
   end

   // rdata holds between enabled reads
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[rd_idx];
      end
   end

endmodule

`default_nettype wire

// ==== hdl/text_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_buffer (
   input  wire logic               clk,
   input  wire logic               we,
   input  wire soc_pkg::mem_wr_t   wr,
   input  wire soc_pkg::text_idx_t char_addr,
   output soc_pkg::data_t          char_data
);
   import soc_pkg::*;

   data_t     mem [text_words];
   text_idx_t wr_idx;

   // buffer only spans the low index bits
   assign wr_idx = wr.word_idx[$bits(text_idx_t)-1:0];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[wr_idx] <= wr.wdata;
      end
   end

   // display side fetch, one cycle latency
   always_ff @(posedge clk) begin
      char_data <= mem[char_addr];
   end

endmodule

`default_nettype wire

// ==== hdl/axi_lite_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_ctrl (
   input  wire logic               clk,
   input  wire logic               rst,
   // write address and data channels
   input  wire logic               awvalid,
   output logic                    awready,
   input  wire soc_pkg::addr_t     awaddr,
   input  wire logic               wvalid,
   output logic                    wready,
   input  wire soc_pkg::data_t     wdata,
   input  wire soc_pkg::strb_t     wstrb,
   // write response
   output logic                    bvalid,
   input  wire logic               bready,
   output soc_pkg::resp_t          bresp,
   // read address and data
   input  wire logic               arvalid,
   output logic                    arready,
   output logic                    rvalid,
   input  wire logic               rready,
   output soc_pkg::data_t          rdata,
   output soc_pkg::resp_t          rresp,
   // datapath side
   output logic                    wr_grant,
   input  wire soc_pkg::decode_t   dec,
   output soc_pkg::mem_wr_t        wr,
   output logic                    ram_we,
   output logic                    text_we,
   output logic                    ram_re,
   output soc_pkg::word_idx_t      rd_idx,
   input  wire soc_pkg::data_t     ram_rdata
);
   import soc_pkg::*;

   ctrl_state_e state;
   ctrl_state_e state_nxt;
   logic        wr_fire;
   logic        rd_fire;
   logic        hit;
   logic        rd_ram;
   resp_t       resp_q;

   assign hit = dec.ram_sel | dec.text_sel;

   // write wins when both channels are presented
   assign wr_fire = (state == st_idle) & awvalid & wvalid;
   assign rd_fire = (state == st_idle) & arvalid & ~(awvalid & wvalid);

   assign wr_grant = wr_fire;
   assign awready  = wr_fire;
   assign wready   = wr_fire;
   assign arready  = rd_fire;

   // write payload straight from the aw and w channels
   assign wr = '{word_idx: awaddr[$bits(word_idx_t)+1:2], wdata: wdata, wstrb: wstrb};

   assign ram_we = wr_fire & dec.ram_sel;
   // text buffer takes whole words, any strobe bit counts
   assign text_we = wr_fire & dec.text_sel & (|wstrb);
   assign ram_re  = (state == st_read_wait) & rd_ram;

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (wr_fire) begin
               state_nxt = st_write_resp;
            end else if (rd_fire) begin
               state_nxt = st_read_wait;
            end
         end
         st_read_wait: begin
            state_nxt = st_read_resp;
         end
         st_read_resp: begin
            if (rready) begin
               state_nxt = st_idle;
            end
         end
         st_write_resp: begin
            if (bready) begin
               state_nxt = st_idle;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // response and read source captured at the address transfer
   always_ff @(posedge clk) begin
      if (wr_fire | rd_fire) begin
         resp_q <= hit ? resp_okay : resp_decerr;
      end
      if (rd_fire) begin
         rd_ram <= dec.ram_sel;
         rd_idx <= dec.word_idx;
      end
   end

   assign bvalid = (state == st_write_resp);
   assign bresp  = resp_q;
   assign rvalid = (state == st_read_resp);
   assign rresp  = resp_q;

   // text and unmapped reads return zero
   assign rdata = rd_ram ? ram_rdata : '0;

endmodule

`default_nettype wire

// ==== hdl/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top (
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire logic               awvalid,
   output logic                    awready,
   input  wire soc_pkg::addr_t     awaddr,
   input  wire logic               wvalid,
   output logic                    wready,
   input  wire soc_pkg::data_t     wdata,
   input  wire soc_pkg::strb_t     wstrb,
   output logic                    bvalid,
   input  wire logic               bready,
   output soc_pkg::resp_t          bresp,
   input  wire logic               arvalid,
   output logic                    arready,
   input  wire soc_pkg::addr_t     araddr,
   output logic                    rvalid,
   input  wire logic               rready,
   output soc_pkg::data_t          rdata,
   output soc_pkg::resp_t          rresp,
   // display fetch port
   input  wire soc_pkg::text_idx_t char_addr,
   output soc_pkg::data_t          char_data
);
   import soc_pkg::*;

   logic      wr_grant;
   decode_t   dec;
   mem_wr_t   wr;
   logic      ram_we;
   logic      text_we;
   logic      ram_re;
   word_idx_t rd_idx;
   data_t     ram_rdata;

   axi_lite_ctrl u_axi_lite_ctrl (
      .clk       (clk       ),
      .rst       (rst       ),
      .awvalid   (awvalid   ),
      .awready   (awready   ),
      .awaddr    (awaddr    ),
      .wvalid    (wvalid    ),
      .wready    (wready    ),
      .wdata     (wdata     ),
      .wstrb     (wstrb     ),
      .bvalid    (bvalid    ),
      .bready    (bready    ),
      .bresp     (bresp     ),
      .arvalid   (arvalid   ),
      .arready   (arready   ),
      .rvalid    (rvalid    ),
      .rready    (rready    ),
      .rdata     (rdata     ),
      .rresp     (rresp     ),
      .wr_grant  (wr_grant  ),
      .dec       (dec       ),
      .wr        (wr        ),
      .ram_we    (ram_we    ),
      .text_we   (text_we   ),
      .ram_re    (ram_re    ),
      .rd_idx    (rd_idx    ),
      .ram_rdata (ram_rdata )
   );

   addr_decode u_addr_decode (
      .awaddr    (awaddr    ),
      .araddr    (araddr    ),
      .wr_grant  (wr_grant  ),
      .dec       (dec       )
   );

   sram_bank u_sram_bank (
      .clk       (clk       ),
      .we        (ram_we    ),
      .re        (ram_re    ),
      .wr        (wr        ),
      .rd_idx    (rd_idx    ),
      .rdata     (ram_rdata )
   );

   text_buffer u_text_buffer (
      .clk       (clk       ),
      .we        (text_we   ),
      .wr        (wr        ),
      .char_addr (char_addr ),
      .char_data (char_data )
   );

endmodule

`default_nettype wire

// ==== tb/soc_top_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top_asserts (
   input wire logic clk,
   input wire logic rst,
   input wire logic awvalid,
   input wire logic awready,
   input wire logic wvalid,
   input wire logic wready,
   input wire logic arvalid,
   input wire logic arready,
   input wire logic bvalid,
   input wire logic bready,
   input wire logic rvalid,
   input wire logic rready
);

   int fail_count = 0;

   // a valid that was not taken is still high on the next cycle
   a_valid_hold: assert property (@(posedge clk) disable iff (rst)
      (!$past(awvalid && !awready) || awvalid) && (!$past(wvalid && !wready) || wvalid) &&
      (!$past(arvalid && !arready) || arvalid) && (!$past(bvalid && !bready) || bvalid) &&
      (!$past(rvalid && !rready) || rvalid))
      else begin
         fail_count++;
         $error("valid dropped before its transfer");
      end

   // both readies pulse for a single cycle with both valids high
   a_ready_pair: assert property (@(posedge clk) disable iff (rst)
      (awready == wready) && (!awready || (awvalid && wvalid && !$past(awready))))
      else begin
         fail_count++;
         $error("awready and wready differ or stay high");
      end

   a_one_resp: assert property (@(posedge clk) disable iff (rst) !(bvalid && rvalid))
      else begin
         fail_count++;
         $error("bvalid and rvalid high together");
      end

   a_read_latency: assert property (@(posedge clk) disable iff (rst)
      arvalid && arready |-> ##2 $rose(rvalid))
      else begin
         fail_count++;
         $error("rvalid did not rise two cycles after the ar transfer");
      end

endmodule

bind soc_top soc_top_asserts u_soc_top_asserts (.*);

`default_nettype wire

// ==== tb/tb_soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;
   import soc_pkg::*;

   // six hex fields per operation in the stimulus file
   localparam int fields  = 6;
   localparam int max_ops = 64;

   logic      clk;
   logic      rst;
   logic      awvalid;
   logic      awready;
   addr_t     awaddr;
   logic      wvalid;
   logic      wready;
   data_t     wdata;
   strb_t     wstrb;
   logic      bvalid;
   logic      bready;
   resp_t     bresp;
   logic      arvalid;
   logic      arready;
   addr_t     araddr;
   logic      rvalid;
   logic      rready;
   data_t     rdata;
   resp_t     rresp;
   text_idx_t char_addr;
   data_t     char_data;

   logic [31:0] stim_mem [max_ops*fields];
   int          n_ops;
   int          limit = 0;
   int          cycles = 0;
   int          errors = 0;
   integer      seed;

   soc_top u_soc_top (.*);

   always #4 clk = ~clk;

   task automatic check_rdata(input data_t got, input data_t exp);
      if (got !== exp) begin
         errors++;
         $display("error: rdata got %h expected %h", got, exp);
      end
   endtask

   task automatic check_resp(input string name, input resp_t got, input resp_t exp);
      if (got !== exp) begin
         errors++;
         $display("error: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_char(input data_t got, input data_t exp);
      if (got !== exp) begin
         errors++;
         $display("error: char_data got %h expected %h", got, exp);
      end
   endtask

   // outputs are sampled 1 ns after the falling edge
   task automatic send_write(input addr_t addr, input data_t data, input strb_t strb,
                             input bit with_read);
      @(negedge clk);
      awvalid = 1'b1;
      awaddr  = addr;
      wvalid  = 1'b1;
      wdata   = data;
      wstrb   = strb;
      if (with_read) begin
         arvalid = 1'b1;
         araddr  = addr;
      end
      #1;
      while (!(awready && wready)) begin
         @(negedge clk);
         #1;
      end
      // a pending read must wait behind the write
      if (arready) begin
         errors++;
         $display("read address was taken in the same cycle as a write");
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
   endtask

   // read address is already on the bus
   task automatic wait_ar();
      #1;
      while (!arready) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      arvalid = 1'b0;
   endtask

   task automatic send_read(input addr_t addr);
      @(negedge clk);
      arvalid = 1'b1;
      araddr  = addr;
      wait_ar();
   endtask

   task automatic take_b(input resp_t exp_resp);
      int delay;
      delay = $random(seed) & 7;
      repeat (delay) @(negedge clk);
      bready = 1'b1;
      #1;
      while (!bvalid) begin
         @(negedge clk);
         #1;
      end
      check_resp("bresp", bresp, exp_resp);
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic take_r(input data_t exp_data, input resp_t exp_resp);
      int delay;
      delay = $random(seed) & 7;
      repeat (delay) @(negedge clk);
      rready = 1'b1;
      #1;
      while (!rvalid) begin
         @(negedge clk);
         #1;
      end
      check_rdata(rdata, exp_data);
      check_resp("rresp", rresp, exp_resp);
      @(negedge clk);
      rready = 1'b0;
   endtask

   // fetch index is address bits 10..2
   task automatic fetch_char(input addr_t addr, input data_t exp);
      @(negedge clk);
      char_addr = addr[10:2];
      @(negedge clk);
      #1;
      check_char(char_data, exp);
   endtask

   task automatic run_op(input int i);
      logic [31:0] op;
      addr_t       addr;
      data_t       data;
      strb_t       strb;
      data_t       exp_data;
      resp_t       exp_resp;
      op       = stim_mem[i*fields];
      addr     = stim_mem[i*fields+1];
      data     = stim_mem[i*fields+2];
      strb     = stim_mem[i*fields+3][3:0];
      exp_data = stim_mem[i*fields+4];
      exp_resp = stim_mem[i*fields+5][1:0];
      case (op)
         32'h1: begin
            send_write(addr, data, strb, 1'b0);
            take_b(exp_resp);
         end
         32'h2: begin
            send_read(addr);
            take_r(exp_data, exp_resp);
         end
         32'h3: begin
            fetch_char(addr, exp_data);
         end
         32'h4: begin
            send_write(addr, data, strb, 1'b1);
            take_b(exp_resp);
            // the read went out together with the write
            wait_ar();
            take_r(exp_data, exp_resp);
         end
         default: begin
            errors++;
            $display("unknown operation %h in stimulus entry %0d", op, i);
         end
      endcase
   endtask

   task automatic end_run(input bit timed_out);
      int assert_fails;
      assert_fails = u_soc_top.u_soc_top_asserts.fail_count;
      $display("errors: %0d, assertion failures: %0d", errors, assert_fails);
      if (!timed_out && errors == 0 && assert_fails == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   endtask

   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout, the run did not finish within %0d cycles", limit);
         end_run(1'b1);
      end
   end

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      awvalid   = 1'b0;
      awaddr    = '0;
      wvalid    = 1'b0;
      wdata     = '0;
      wstrb     = '0;
      bready    = 1'b0;
      arvalid   = 1'b0;
      araddr    = '0;
      rready    = 1'b0;
      char_addr = '0;
      seed      = 32'h7a04;
      $readmemh("tb/soc_stimulus.txt", stim_mem);
      n_ops = 0;
      // op f ends the list
      while (n_ops < max_ops && stim_mem[n_ops*fields] != 32'hf) begin
         n_ops++;
      end
      if (n_ops == max_ops) begin
         errors++;
         $display("the stimulus file has no end entry");
      end
      limit = n_ops * 20 + 100;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < n_ops; i++) begin
         run_op(i);
      end
      repeat (2) @(negedge clk);
      end_run(1'b0);
   end

endmodule

`default_nettype wire

// ==== tb/soc_stimulus.txt ====
// columns: op addr data strb exp_data exp_resp, all hex
// op 1 write, 2 read, 3 char fetch, 4 write and read presented together, f end
// full word RAM write and read back
1 1c000010 deadbeef f 00000000 0
2 1c000010 00000000 0 deadbeef 0
// strobes 0101 keep bytes 3 and 1 of deadbeef
1 1c000010 11223344 5 00000000 0
2 1c000010 00000000 0 de22be44 0
1 1c000020 01234567 f 00000000 0
1 1c000020 89abcdef 8 00000000 0
2 1c000020 00000000 0 89234567 0
// text buffer, index 10 and 11; one strobe bit writes the whole word
1 00010040 00000741 f 00000000 0
3 00010040 00000000 0 00000741 0
2 00010040 00000000 0 00000000 0
1 00010044 12345678 1 00000000 0
3 00010044 00000000 0 12345678 0
// unmapped, same word index as 1c000010
1 20000010 55aa55aa f 00000000 3
2 20000010 00000000 0 00000000 3
2 1c000010 00000000 0 de22be44 0
// write and read together, the write goes first
4 1c000100 a5a5a5a5 f a5a5a5a5 0
1 1c000ffc 0badc0de f 00000000 0
2 1c000ffc 00000000 0 0badc0de 0
4 1c000010 77777777 3 de227777 0
f 00000000 00000000 0 00000000 0

// ==== sim.f ====
hdl/soc_pkg.sv
hdl/addr_decode.sv
hdl/sram_bank.sv
hdl/text_buffer.sv
hdl/axi_lite_ctrl.sv
hdl/soc_top.sv
tb/soc_top_asserts.sv
tb/tb_soc_top.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_soc_top
FILELIST   = sim.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
RUN_FLAGS  = +verilator+error+limit+100
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
